// ==== build.f ====
rtl/accel_pkg.sv
rtl/packet_mem.sv
rtl/mem_arbiter.sv
rtl/pattern_scanner.sv
rtl/accel_regs.sv
rtl/accel_top.sv
tests/accel_properties.sv
tests/accel_tb.sv

// ==== rtl/accel_pkg.sv ====
package accel_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int IO_DATA_WIDTH   = 32;
  localparam int IO_STRB_WIDTH   = 4;
  localparam int IO_ADDR_WIDTH   = 16;
  localparam int MEM_WORDS       = 1024;
  localparam int MEM_ADDR_WIDTH  = 10;
  localparam int ACCEL_COUNT     = 4;
  localparam int ACCEL_SEL_WIDTH = 2;
  localparam int LEN_WIDTH       = 16;
  localparam int PAT_WIDTH       = 16;

  // --------------------------------------------------
  // host address map
  // --------------------------------------------------
  localparam int MEM_WINDOW_BIT = 15;
  localparam int SUMMARY_BIT    = 7;
  // word address and scanner select start at these bits
  localparam int ADDR_WORD_LSB  = 2;
  localparam int ADDR_SEL_LSB   = 4;
  localparam int REG_SEL_WIDTH  = 2;

  localparam logic [REG_SEL_WIDTH-1:0] REG_CTRL    = 2'd0;
  localparam logic [REG_SEL_WIDTH-1:0] REG_LEN     = 2'd1;
  localparam logic [REG_SEL_WIDTH-1:0] REG_ADDR    = 2'd2;
  localparam logic [REG_SEL_WIDTH-1:0] REG_PATTERN = 2'd3;

  // control register bits
  localparam int CTRL_START_BIT   = 0;
  localparam int CTRL_PENDING_BIT = 0;
  localparam int CTRL_READY_BIT   = 1;
  localparam int CTRL_DONE_BIT    = 8;
  localparam int CTRL_MATCH_BIT   = 9;

  // scanner FSM encoding
  localparam logic [1:0] SCAN_IDLE  = 2'd0;
  localparam logic [1:0] SCAN_FETCH = 2'd1;
  localparam logic [1:0] SCAN_WAIT  = 2'd2;

endpackage

// ==== rtl/accel_regs.sv ====
`timescale 1ns/1ps

module accel_regs (
  input  logic                                                    clk,
  input  logic                                                    rst,

  input  logic                                                    io_en,
  input  logic                                                    io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]                      io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0]                      io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]                      io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]                      io_rd_data,
  output logic                                                    io_rd_valid,

  output logic [accel_pkg::ACCEL_COUNT-1:0]                        cmd_valid,
  output logic [accel_pkg::ACCEL_COUNT*(accel_pkg::MEM_ADDR_WIDTH+2)-1:0] cmd_addr,
  output logic [accel_pkg::ACCEL_COUNT*accel_pkg::LEN_WIDTH-1:0]    cmd_len,
  output logic [accel_pkg::ACCEL_COUNT*accel_pkg::PAT_WIDTH-1:0]    cmd_pattern,
  input  logic [accel_pkg::ACCEL_COUNT-1:0]                        cmd_ready,
  input  logic [accel_pkg::ACCEL_COUNT-1:0]                        status_done,
  input  logic [accel_pkg::ACCEL_COUNT-1:0]                        status_match,

  output logic                                                    host_req,
  output logic                                                    host_wen,
  output logic [accel_pkg::IO_STRB_WIDTH-1:0]                      host_strb,
  output logic [accel_pkg::MEM_ADDR_WIDTH-1:0]                     host_addr,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]                      host_wr_data,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]                      host_rd_data
);

  import accel_pkg::*;

  localparam int AW = MEM_ADDR_WIDTH + 2;

  logic [AW-1:0]        addr_q [ACCEL_COUNT];
  logic [LEN_WIDTH-1:0] len_q  [ACCEL_COUNT];
  logic [PAT_WIDTH-1:0] pat_q  [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0] pending_q;

  logic                     mem_rd_q;
  logic [IO_DATA_WIDTH-1:0] rd_data_q;
  logic                     rd_valid_q;
  logic [IO_DATA_WIDTH-1:0] reg_rd_data;

  logic                       mem_sel;
  logic                       sum_sel;
  logic [ACCEL_SEL_WIDTH-1:0] acc_idx;
  logic [REG_SEL_WIDTH-1:0]   reg_idx;

  assign mem_sel = io_addr[MEM_WINDOW_BIT];
  assign sum_sel = io_addr[SUMMARY_BIT];
  assign acc_idx = io_addr[ADDR_SEL_LSB +: ACCEL_SEL_WIDTH];
  assign reg_idx = io_addr[ADDR_WORD_LSB +: REG_SEL_WIDTH];

  // memory window accesses go straight to the arbiter, which always grants the host
  assign host_req     = io_en & mem_sel;
  assign host_wen     = io_wen;
  assign host_strb    = io_strb;
  assign host_addr    = io_addr[ADDR_WORD_LSB +: MEM_ADDR_WIDTH];
  assign host_wr_data = io_wr_data;

  // --------------------------------------------------
  // register read mux
  // --------------------------------------------------
  always_comb begin
    reg_rd_data = '0;
    if (sum_sel) begin
      reg_rd_data[ACCEL_COUNT-1:0] = status_done;
    end else begin
      case (reg_idx)
        REG_CTRL: begin
          reg_rd_data[CTRL_PENDING_BIT] = pending_q[acc_idx];
          reg_rd_data[CTRL_READY_BIT]   = cmd_ready[acc_idx];
          reg_rd_data[CTRL_DONE_BIT]    = status_done[acc_idx];
          reg_rd_data[CTRL_MATCH_BIT]   = status_match[acc_idx];
        end
        REG_LEN:     reg_rd_data[LEN_WIDTH-1:0] = len_q[acc_idx];
        REG_ADDR:    reg_rd_data[AW-1:0]        = addr_q[acc_idx];
        default:     reg_rd_data[PAT_WIDTH-1:0] = pat_q[acc_idx];
      endcase
    end
  end

  // --------------------------------------------------
  // command registers and read return
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    // a scanner takes its command when pending meets ready
    pending_q <= pending_q & ~cmd_ready;

    if (io_en && io_wen && !mem_sel && !sum_sel) begin
      case (reg_idx)
        REG_CTRL: begin
          if (io_strb[0] && io_wr_data[CTRL_START_BIT]) begin
            pending_q[acc_idx] <= 1'b1;
          end
        end
        REG_LEN:  len_q[acc_idx]  <= io_wr_data[LEN_WIDTH-1:0];
        REG_ADDR: addr_q[acc_idx] <= io_wr_data[AW-1:0];
        default:  pat_q[acc_idx]  <= io_wr_data[PAT_WIDTH-1:0];
      endcase
    end

    // RAM output is valid the cycle after the grant, so register it once more
    mem_rd_q   <= io_en & ~io_wen & mem_sel;
    rd_valid_q <= 1'b0;
    if (mem_rd_q) begin
      rd_data_q  <= host_rd_data;
      rd_valid_q <= 1'b1;
    end
    if (io_en && !io_wen && !mem_sel) begin
      rd_data_q  <= reg_rd_data;
      rd_valid_q <= 1'b1;
    end

    if (rst) begin
      pending_q  <= '0;
      mem_rd_q   <= 1'b0;
      rd_valid_q <= 1'b0;
    end
  end

  assign io_rd_data  = rd_data_q;
  assign io_rd_valid = rd_valid_q;
  assign cmd_valid   = pending_q;

  for (genvar n = 0; n < ACCEL_COUNT; n++) begin : g_cmd
    assign cmd_addr[n*AW +: AW]                   = addr_q[n];
    assign cmd_len[n*LEN_WIDTH +: LEN_WIDTH]      = len_q[n];
    assign cmd_pattern[n*PAT_WIDTH +: PAT_WIDTH]  = pat_q[n];
  end

endmodule

// ==== rtl/accel_top.sv ====
`timescale 1ns/1ps

module accel_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               io_en,
  input  logic                               io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                               io_rd_valid
);

  import accel_pkg::*;

  localparam int AW = MEM_ADDR_WIDTH + 2;

  logic [ACCEL_COUNT-1:0]                cmd_valid;
  logic [ACCEL_COUNT*AW-1:0]             cmd_addr;
  logic [ACCEL_COUNT*LEN_WIDTH-1:0]      cmd_len;
  logic [ACCEL_COUNT*PAT_WIDTH-1:0]      cmd_pattern;
  logic [ACCEL_COUNT-1:0]                cmd_ready;
  logic [ACCEL_COUNT-1:0]                status_done;
  logic [ACCEL_COUNT-1:0]                status_match;

  logic [ACCEL_COUNT-1:0]                mem_req;
  logic [ACCEL_COUNT*MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [ACCEL_COUNT-1:0]                mem_gnt;

  logic                      host_req;
  logic                      host_wen;
  logic [IO_STRB_WIDTH-1:0]  host_strb;
  logic [MEM_ADDR_WIDTH-1:0] host_addr;
  logic [IO_DATA_WIDTH-1:0]  host_wr_data;

  logic                      ram_en;
  logic                      ram_wen;
  logic [IO_STRB_WIDTH-1:0]  ram_strb;
  logic [MEM_ADDR_WIDTH-1:0] ram_addr;
  logic [IO_DATA_WIDTH-1:0]  ram_wr_data;
  logic [IO_DATA_WIDTH-1:0]  ram_rd_data;

  accel_regs accel_regs_i (
    .clk, .rst,
    .io_en, .io_wen, .io_strb, .io_addr, .io_wr_data, .io_rd_data, .io_rd_valid,
    .cmd_valid, .cmd_addr, .cmd_len, .cmd_pattern, .cmd_ready,
    .status_done, .status_match,
    .host_req, .host_wen, .host_strb, .host_addr, .host_wr_data,
    .host_rd_data (ram_rd_data)
  );

  // all scanners see the same read bus and sample it after their own grant
  for (genvar n = 0; n < ACCEL_COUNT; n++) begin : g_scan
    pattern_scanner pattern_scanner_i (
      .clk, .rst,
      .cmd_valid    (cmd_valid[n]),
      .cmd_addr     (cmd_addr[n*AW +: AW]),
      .cmd_len      (cmd_len[n*LEN_WIDTH +: LEN_WIDTH]),
      .cmd_pattern  (cmd_pattern[n*PAT_WIDTH +: PAT_WIDTH]),
      .cmd_ready    (cmd_ready[n]),
      .status_done  (status_done[n]),
      .status_match (status_match[n]),
      .mem_req      (mem_req[n]),
      .mem_addr     (mem_addr[n*MEM_ADDR_WIDTH +: MEM_ADDR_WIDTH]),
      .mem_gnt      (mem_gnt[n]),
      .mem_rd_data  (ram_rd_data)
    );
  end

  // the host always wins, so its grant needs no return path
  mem_arbiter mem_arbiter_i (
    .clk, .rst,
    .host_req, .host_wen, .host_strb, .host_addr, .host_wr_data,
    .mem_req, .mem_addr, .mem_gnt,
    .host_gnt (),
    .ram_en, .ram_wen, .ram_strb, .ram_addr, .ram_wr_data
  );

  packet_mem packet_mem_i (
    .clk,
    .ram_en, .ram_wen, .ram_strb, .ram_addr, .ram_wr_data, .ram_rd_data
  );

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,

  input  logic                                                 host_req,
  input  logic                                                 host_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]                   host_strb,
  input  logic [accel_pkg::MEM_ADDR_WIDTH-1:0]                  host_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]                   host_wr_data,

  input  logic [accel_pkg::ACCEL_COUNT-1:0]                     mem_req,
  input  logic [accel_pkg::ACCEL_COUNT*accel_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
  output logic [accel_pkg::ACCEL_COUNT-1:0]                     mem_gnt,
  output logic                                                 host_gnt,

  output logic                                                 ram_en,
  output logic                                                 ram_wen,
  output logic [accel_pkg::IO_STRB_WIDTH-1:0]                   ram_strb,
  output logic [accel_pkg::MEM_ADDR_WIDTH-1:0]                  ram_addr,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]                   ram_wr_data
);

  import accel_pkg::*;

  logic [ACCEL_SEL_WIDTH-1:0] last_q;
  logic [ACCEL_SEL_WIDTH-1:0] win_idx;
  logic                       win_found;

  // search starts one past the last scanner served and wraps back to it
  always_comb begin
    logic [ACCEL_SEL_WIDTH-1:0] cand;
    win_idx   = last_q;
    win_found = 1'b0;
    for (int k = 1; k <= ACCEL_COUNT; k++) begin
      cand = last_q + ACCEL_SEL_WIDTH'(k);
      if (!win_found && mem_req[cand]) begin
        win_found = 1'b1;
        win_idx   = cand;
      end
    end
  end

  always_comb begin
    host_gnt = host_req;
    mem_gnt  = '0;
    if (!host_req && win_found) begin
      mem_gnt[win_idx] = 1'b1;
    end
  end

  // scanners only ever read
  assign ram_en      = host_req | win_found;
  assign ram_wen     = host_req & host_wen;
  assign ram_strb    = host_strb;
  assign ram_addr    = host_req ? host_addr : mem_addr[win_idx*MEM_ADDR_WIDTH +: MEM_ADDR_WIDTH];
  assign ram_wr_data = host_wr_data;

  always_ff @(posedge clk) begin
    if (!host_req && win_found) begin
      last_q <= win_idx;
    end
    if (rst) begin
      last_q <= ACCEL_SEL_WIDTH'(ACCEL_COUNT - 1);
    end
  end

endmodule

// ==== rtl/packet_mem.sv ====
`timescale 1ns/1ps

module packet_mem (
  input  logic                                clk,
  input  logic                                ram_en,
  input  logic                                ram_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]  ram_strb,
  input  logic [accel_pkg::MEM_ADDR_WIDTH-1:0] ram_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]  ram_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]  ram_rd_data
);

  import accel_pkg::*;

  logic [IO_DATA_WIDTH-1:0] mem [MEM_WORDS];

  // a write leaves the read register untouched
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_wen) begin
        for (int b = 0; b < IO_STRB_WIDTH; b++) begin
          if (ram_strb[b]) begin
            mem[ram_addr][8*b +: 8] <= ram_wr_data[8*b +: 8];
          end
        end
      end else begin
        ram_rd_data <= mem[ram_addr];
      end
    end
  end

endmodule

// ==== rtl/pattern_scanner.sv ====
`timescale 1ns/1ps

module pattern_scanner (
  input  logic                                  clk,
  input  logic                                  rst,

  input  logic                                  cmd_valid,
  input  logic [accel_pkg::MEM_ADDR_WIDTH+1:0]   cmd_addr,
  input  logic [accel_pkg::LEN_WIDTH-1:0]        cmd_len,
  input  logic [accel_pkg::PAT_WIDTH-1:0]        cmd_pattern,
  output logic                                  cmd_ready,

  output logic                                  status_done,
  output logic                                  status_match,

  output logic                                  mem_req,
  output logic [accel_pkg::MEM_ADDR_WIDTH-1:0]   mem_addr,
  input  logic                                  mem_gnt,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]    mem_rd_data
);

  import accel_pkg::*;

  logic [1:0]                state_q;
  logic [MEM_ADDR_WIDTH-1:0] addr_q;
  logic [LEN_WIDTH-1:0]      remain_q;
  logic [PAT_WIDTH-1:0]      pat_q;
  logic [7:0]                prev_byte_q;
  logic                      prev_valid_q;
  logic                      done_q;
  logic                      match_q;

  logic                      word_hit;
  logic [7:0]                last_byte;

  // --------------------------------------------------
  // byte walk over the word in flight
  // --------------------------------------------------

  // bytes go low lane first, and the byte before lane 0 comes from the previous word
  always_comb begin
    logic [7:0] prev;
    logic       prev_ok;
    logic [7:0] cur;
    word_hit = 1'b0;
    prev     = prev_byte_q;
    prev_ok  = prev_valid_q;
    for (int b = 0; b < IO_STRB_WIDTH; b++) begin
      cur = mem_rd_data[8*b +: 8];
      // lanes past the end of the range are skipped
      if (LEN_WIDTH'(b) < remain_q) begin
        if (prev_ok && prev == pat_q[7:0] && cur == pat_q[PAT_WIDTH-1:8]) begin
          word_hit = 1'b1;
        end
        prev    = cur;
        prev_ok = 1'b1;
      end
    end
    last_byte = prev;
  end

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    case (state_q)
      SCAN_IDLE: begin
        if (cmd_valid) begin
          addr_q       <= cmd_addr[MEM_ADDR_WIDTH+1:2];
          remain_q     <= cmd_len;
          pat_q        <= cmd_pattern;
          prev_valid_q <= 1'b0;
          match_q      <= 1'b0;
          // fewer than two bytes can never hold the pattern
          if (cmd_len < LEN_WIDTH'(2)) begin
            done_q <= 1'b1;
          end else begin
            done_q  <= 1'b0;
            state_q <= SCAN_FETCH;
          end
        end
      end
      SCAN_FETCH: begin
        if (mem_gnt) begin
          state_q <= SCAN_WAIT;
        end
      end
      SCAN_WAIT: begin
        prev_byte_q  <= last_byte;
        prev_valid_q <= 1'b1;
        addr_q       <= addr_q + 1'b1;
        if (word_hit) begin
          match_q <= 1'b1;
        end
        if (remain_q <= LEN_WIDTH'(IO_STRB_WIDTH)) begin
          done_q  <= 1'b1;
          state_q <= SCAN_IDLE;
        end else begin
          remain_q <= remain_q - LEN_WIDTH'(IO_STRB_WIDTH);
          state_q  <= SCAN_FETCH;
        end
      end
      default: begin
        state_q <= SCAN_IDLE;
      end
    endcase
    if (rst) begin
      state_q <= SCAN_IDLE;
      done_q  <= 1'b0;
      match_q <= 1'b0;
    end
  end

  assign cmd_ready    = (state_q == SCAN_IDLE);
  assign mem_req      = (state_q == SCAN_FETCH);
  assign mem_addr     = addr_q;
  assign status_done  = done_q;
  assign status_match = match_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module accel_tb -o accel_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/accel_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1

// ==== tests/accel_properties.sv ====
`timescale 1ns/1ps

module accel_properties (
  input logic                                clk,
  input logic                                rst,
  input logic                                io_en,
  input logic                                io_wen,
  input logic [accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input logic                                io_rd_valid,
  input logic                                host_req,
  input logic [accel_pkg::ACCEL_COUNT-1:0]   mem_gnt
);

  import accel_pkg::*;

  logic reg_rd;
  logic mem_rd;

  assign reg_rd = io_en && !io_wen && !io_addr[MEM_WINDOW_BIT];
  assign mem_rd = io_en && !io_wen && io_addr[MEM_WINDOW_BIT];

  gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(mem_gnt))
    else $error("more than one scanner granted in the same cycle");

  host_first: assert property (@(posedge clk) disable iff (rst) host_req |-> mem_gnt == '0)
    else $error("scanner granted while the host requested memory");

  // register reads return after one cycle, memory reads after two
  reg_rd_return: assert property (@(posedge clk) disable iff (rst) reg_rd |=> io_rd_valid)
    else $error("register read did not return one cycle later");

  mem_rd_return: assert property (@(posedge clk) disable iff (rst) mem_rd |-> ##2 io_rd_valid)
    else $error("memory read did not return two cycles later");

  rd_valid_source: assert property (@(posedge clk) disable iff (rst)
      io_rd_valid |-> $past(reg_rd) || $past(mem_rd, 2))
    else $error("read valid pulse without a matching read");

endmodule

bind accel_top accel_properties accel_properties_i (
  .clk, .rst, .io_en, .io_wen, .io_addr, .io_rd_valid, .host_req, .mem_gnt
);

// ==== tests/accel_tb.sv ====
`timescale 1ns/1ps

module accel_tb;

  import accel_pkg::*;

  localparam int          WAIT_LIMIT   = 64;
  localparam int          DONE_LIMIT   = 2000;
  localparam logic [15:0] MEM_BASE     = 16'h8000;
  localparam logic [15:0] SUMMARY_ADDR = 16'h0080;

  logic                     clk;
  logic                     rst;
  logic                     io_en;
  logic                     io_wen;
  logic [IO_STRB_WIDTH-1:0] io_strb;
  logic [IO_ADDR_WIDTH-1:0] io_addr;
  logic [IO_DATA_WIDTH-1:0] io_wr_data;
  logic [IO_DATA_WIDTH-1:0] io_rd_data;
  logic                     io_rd_valid;

  // byte image of everything the host wrote to packet memory
  logic [7:0] shadow [MEM_WORDS*4];

  string cur_test;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  accel_top accel_top_i (
    .clk, .rst, .io_en, .io_wen, .io_strb, .io_addr, .io_wr_data, .io_rd_data, .io_rd_valid
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // host port access
  // --------------------------------------------------
  // tasks start and end 2 ns after a rising edge
  task automatic io_write(input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = strb;
    io_addr    = addr;
    io_wr_data = data;
    @(posedge clk);
    #2;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic io_read(input logic [15:0] addr, output logic [31:0] data);
    int n;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(posedge clk);
    #2;
    io_en = 1'b0;
    n = 0;
    while (!io_rd_valid && n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    data = io_rd_data;
    if (!io_rd_valid) begin
      $display("timeout: no read data returned for address %h", addr);
      test_errors++;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s %s: expected %h actual %h", cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, test_errors);
      tests_failed++;
    end
  endtask

  function automatic logic [15:0] mem_io_addr(input int word);
    return MEM_BASE | 16'(word << 2);
  endfunction

  function automatic logic [15:0] reg_io_addr(input int n, input logic [1:0] r);
    return 16'(n << 4) | 16'({r, 2'b00});
  endfunction

  function automatic logic [31:0] shadow_word(input int word);
    return {shadow[4*word+3], shadow[4*word+2], shadow[4*word+1], shadow[4*word]};
  endfunction

  task automatic mem_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[4*word+b] = data[8*b +: 8];
      end
    end
    io_write(mem_io_addr(word), data, strb);
  endtask

  // a match needs byte i equal to the pattern low byte and byte i+1 to the high byte
  function automatic logic model_match(input int base, input int len, input logic [15:0] pat);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i + 1 < len; i++) begin
      if (shadow[base+i] == pat[7:0] && shadow[base+i+1] == pat[15:8]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // --------------------------------------------------
  // scanner control
  // --------------------------------------------------
  task automatic program_scan(input int n, input int base, input int len,
                              input logic [15:0] pat);
    io_write(reg_io_addr(n, REG_ADDR), 32'(base), 4'hf);
    io_write(reg_io_addr(n, REG_LEN), 32'(len), 4'hf);
    io_write(reg_io_addr(n, REG_PATTERN), {16'h0, pat}, 4'hf);
  endtask

  task automatic start_scan(input int n);
    io_write(reg_io_addr(n, REG_CTRL), 32'h1, 4'h1);
  endtask

  // done from an earlier scan is stale until pending has cleared
  task automatic wait_done(input int n, output logic [31:0] ctrl);
    int polls;
    polls = 0;
    io_read(reg_io_addr(n, REG_CTRL), ctrl);
    while (!(ctrl[CTRL_DONE_BIT] && !ctrl[CTRL_PENDING_BIT]) && polls < DONE_LIMIT) begin
      io_read(reg_io_addr(n, REG_CTRL), ctrl);
      polls++;
    end
    if (!ctrl[CTRL_DONE_BIT] || ctrl[CTRL_PENDING_BIT]) begin
      $display("timeout: scanner %0d did not finish its scan", n);
      test_errors++;
    end
  endtask

  task automatic scan_case(input string what, input int base, input int len,
                           input logic [15:0] pat);
    logic [31:0] ctrl;
    program_scan(0, base, len, pat);
    start_scan(0);
    wait_done(0, ctrl);
    check_value({what, " match"}, 32'(model_match(base, len, pat)),
                32'(ctrl[CTRL_MATCH_BIT]));
  endtask

  initial begin
    logic [31:0] rd;
    int          base [ACCEL_COUNT];
    int          len [ACCEL_COUNT];
    logic [15:0] pat [ACCEL_COUNT];
    int          pos;
    int          word;
    logic [3:0]  strb;

    void'($urandom(32'ha649_4d3d));
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors  = 0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset");
    io_read(SUMMARY_ADDR, rd);
    check_value("summary", 32'h0, rd);
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      io_read(reg_io_addr(n, REG_CTRL), rd);
      check_value($sformatf("ctrl %0d", n), 32'h2, rd & 32'h3);
    end
    end_test();

    start_test("memory");
    for (int w = 0; w < 16; w++) begin
      mem_write(w, $urandom, 4'hf);
    end
    for (int w = 0; w < 16; w += 2) begin
      strb = 4'($urandom);
      mem_write(w, $urandom, strb);
    end
    for (int w = 0; w < 16; w++) begin
      io_read(mem_io_addr(w), rd);
      check_value($sformatf("word %0d", w), shadow_word(w), rd);
    end
    end_test();

    start_test("registers");
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      base[n] = 4 * int'($urandom_range(0, 1023));
      len[n]  = int'($urandom_range(0, 65535));
      pat[n]  = 16'($urandom);
      program_scan(n, base[n], len[n], pat[n]);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      io_read(reg_io_addr(n, REG_ADDR), rd);
      check_value($sformatf("addr %0d", n), 32'(base[n]), rd);
      io_read(reg_io_addr(n, REG_LEN), rd);
      check_value($sformatf("len %0d", n), 32'(len[n]), rd);
      io_read(reg_io_addr(n, REG_PATTERN), rd);
      check_value($sformatf("pattern %0d", n), {16'h0, pat[n]}, rd);
    end
    end_test();

    // bytes 256 to 271 hold 0x40 upward
    start_test("single scans");
    for (int w = 0; w < 4; w++) begin
      mem_write(64 + w, 32'h4342_4140 + 32'h0404_0404 * w, 4'hf);
    end
    scan_case("one word", 256, 8, 16'h4241);
    scan_case("straddle", 256, 8, 16'h4443);
    scan_case("past length", 256, 6, 16'h4645);
    scan_case("length one", 256, 1, 16'h4140);
    end_test();

    start_test("parallel");
    for (int w = 128; w < 192; w++) begin
      mem_write(w, $urandom, 4'hf);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      base[n] = 4 * (128 + 16 * n + int'($urandom_range(0, 3)));
      len[n]  = int'($urandom_range(8, 47));
      if ($urandom_range(0, 1) == 1) begin
        pos    = base[n] + int'($urandom_range(0, len[n] - 2));
        pat[n] = {shadow[pos+1], shadow[pos]};
      end else begin
        pat[n] = 16'($urandom);
      end
      program_scan(n, base[n], len[n], pat[n]);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      start_scan(n);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      wait_done(n, rd);
      check_value($sformatf("match %0d", n), 32'(model_match(base[n], len[n], pat[n])),
                  32'(rd[CTRL_MATCH_BIT]));
    end
    io_read(SUMMARY_ADDR, rd);
    check_value("summary", 32'hf, rd);
    end_test();

    // long scans keep every scanner requesting while the host reads
    start_test("host priority");
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      base[n] = 512;
      len[n]  = 256 - 4 * n;
      pat[n]  = 16'($urandom);
      program_scan(n, base[n], len[n], pat[n]);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      start_scan(n);
    end
    for (int k = 0; k < 16; k++) begin
      word = int'($urandom_range(0, 15));
      io_read(mem_io_addr(word), rd);
      check_value($sformatf("word %0d", word), shadow_word(word), rd);
    end
    for (int n = 0; n < ACCEL_COUNT; n++) begin
      wait_done(n, rd);
      check_value($sformatf("match %0d", n), 32'(model_match(base[n], len[n], pat[n])),
                  32'(rd[CTRL_MATCH_BIT]));
    end
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
